/* include/tcdm_config.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Local TCDM sizing: ports, banks, word width and address layout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TCDM_CONFIG_SVH
`define TCDM_CONFIG_SVH

// Tile request ports
`define TCDM_NUM_PORTS 4

// Word-interleaved banks
`define TCDM_NUM_BANKS 4

`define TCDM_DATA_WIDTH 32

// Words per bank
`define TCDM_BANK_ROWS 64

// Byte address, row + bank + byte offset
`define TCDM_ADDR_WIDTH 10

`endif

/* hw/tcdm_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Local TCDM types: data words, strobes, initiator indices and addresses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "tcdm_config.svh"

package tcdm_pkg;

  typedef logic [`TCDM_DATA_WIDTH-1:0]            tcdm_data_t;
  typedef logic [`TCDM_DATA_WIDTH/8-1:0]          tcdm_strb_t;
  typedef logic [$clog2(`TCDM_NUM_PORTS)-1:0]     tcdm_ini_t;
  typedef logic [$clog2(`TCDM_NUM_BANKS)-1:0]     tcdm_bank_idx_t;
  typedef logic [$clog2(`TCDM_BANK_ROWS)-1:0]     tcdm_row_t;
  typedef logic [`TCDM_ADDR_WIDTH-1:0]            tcdm_addr_t;

  // Word interleaving puts the bank right above the byte offset
  typedef struct packed {
    tcdm_row_t                                  row;
    tcdm_bank_idx_t                             bank;
    logic [$clog2(`TCDM_DATA_WIDTH/8)-1:0]      offset;
  } tcdm_addr_fields_t;

  typedef union packed {
    tcdm_addr_t        raw;
    tcdm_addr_fields_t fields;
  } tcdm_addr_u;

endpackage

/* hw/tcdm_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Valid/ready request and response bundles of the local TCDM path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
interface tcdm_req_if;
  import tcdm_pkg::*;

  logic       valid;
  logic       ready;
  tcdm_addr_u addr;
  logic       wen;
  tcdm_data_t wdata;
  tcdm_strb_t be;
  // Port that issued the request
  tcdm_ini_t  ini;

  modport master (
    output valid, addr, wen, wdata, be, ini,
    input  ready
  );

  modport slave (
    input  valid, addr, wen, wdata, be, ini,
    output ready
  );

  modport monitor (
    input valid, ready, addr, wen, wdata, be, ini
  );

endinterface

interface tcdm_resp_if;
  import tcdm_pkg::*;

  logic       valid;
  logic       ready;
  tcdm_data_t rdata;
  tcdm_ini_t  ini;

  modport master (
    output valid, rdata, ini,
    input  ready
  );

  modport slave (
    input  valid, rdata, ini,
    output ready
  );

  modport monitor (
    input valid, ready, rdata, ini
  );

endinterface

/* hw/tcdm_req_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Request stage: per-port capture, word-align decode, one outstanding request
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "tcdm_config.svh"

module tcdm_req_stage (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  input  logic                 [`TCDM_NUM_PORTS-1:0] req_valid_i,
  output logic                 [`TCDM_NUM_PORTS-1:0] req_ready_o,
  input  tcdm_pkg::tcdm_addr_t [`TCDM_NUM_PORTS-1:0] req_addr_i,
  input  logic                 [`TCDM_NUM_PORTS-1:0] req_wen_i,
  input  tcdm_pkg::tcdm_data_t [`TCDM_NUM_PORTS-1:0] req_wdata_i,
  input  tcdm_pkg::tcdm_strb_t [`TCDM_NUM_PORTS-1:0] req_be_i,
  tcdm_req_if.master                                 dec_o    [`TCDM_NUM_PORTS],
  tcdm_resp_if.monitor                               resp_mon [`TCDM_NUM_PORTS]
);
  import tcdm_pkg::*;

  logic       [`TCDM_NUM_PORTS-1:0] in_valid_q;
  logic       [`TCDM_NUM_PORTS-1:0] dec_valid_q;
  logic       [`TCDM_NUM_PORTS-1:0] outst_q;
  logic       [`TCDM_NUM_PORTS-1:0] accept;
  logic       [`TCDM_NUM_PORTS-1:0] dec_ready;
  logic       [`TCDM_NUM_PORTS-1:0] rsp_done;
  tcdm_addr_u [`TCDM_NUM_PORTS-1:0] addr_q;
  logic       [`TCDM_NUM_PORTS-1:0] wen_q;
  tcdm_data_t [`TCDM_NUM_PORTS-1:0] wdata_q;
  tcdm_strb_t [`TCDM_NUM_PORTS-1:0] be_q;

  // Busy from capture until the response is taken
  assign req_ready_o = ~(in_valid_q | dec_valid_q | outst_q);
  assign accept      = req_valid_i & req_ready_o;

  for (genvar p = 0; p < `TCDM_NUM_PORTS; p++) begin : gen_port
    assign dec_o[p].valid = dec_valid_q[p];
    assign dec_o[p].addr  = addr_q[p];
    assign dec_o[p].wen   = wen_q[p];
    assign dec_o[p].wdata = wdata_q[p];
    assign dec_o[p].be    = be_q[p];
    assign dec_o[p].ini   = tcdm_ini_t'(p);
    assign dec_ready[p]   = dec_o[p].ready;
    assign rsp_done[p]    = resp_mon[p].valid & resp_mon[p].ready;

    a_one_outstanding: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      accept[p] |-> !outst_q[p]);
    // The port's response never arrives unless its request was granted
    a_resp_needs_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rsp_done[p] |-> outst_q[p]);
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      in_valid_q  <= '0;
      dec_valid_q <= '0;
      outst_q     <= '0;
    end else begin
      for (int p = 0; p < `TCDM_NUM_PORTS; p++) begin
        if (accept[p]) begin
          in_valid_q[p] <= 1'b1;
        end else if (in_valid_q[p]) begin
          in_valid_q[p]  <= 1'b0;
          dec_valid_q[p] <= 1'b1;
        end else if (dec_valid_q[p] && dec_ready[p]) begin
          dec_valid_q[p] <= 1'b0;
          outst_q[p]     <= 1'b1;
        end else if (rsp_done[p]) begin
          outst_q[p] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int p = 0; p < `TCDM_NUM_PORTS; p++) begin
      if (accept[p]) begin
        addr_q[p].raw <= req_addr_i[p];
        wen_q[p]      <= req_wen_i[p];
        wdata_q[p]    <= req_wdata_i[p];
        be_q[p]       <= req_be_i[p];
      end else if (in_valid_q[p]) begin
        // Banks see word addresses only
        addr_q[p].fields.offset <= '0;
      end
    end
  end

endmodule

/* hw/tcdm_bank_arbiter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Per-bank round-robin arbiter between the decoded port requests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "tcdm_config.svh"

module tcdm_bank_arbiter (
  input  logic       clk_i,
  input  logic       rst_n_i,
  tcdm_req_if.slave  req_s  [`TCDM_NUM_PORTS],
  tcdm_req_if.master bank_m [`TCDM_NUM_BANKS]
);
  import tcdm_pkg::*;

  logic       [`TCDM_NUM_PORTS-1:0]                      p_valid;
  tcdm_addr_u [`TCDM_NUM_PORTS-1:0]                      p_addr;
  logic       [`TCDM_NUM_PORTS-1:0]                      p_wen;
  tcdm_data_t [`TCDM_NUM_PORTS-1:0]                      p_wdata;
  tcdm_strb_t [`TCDM_NUM_PORTS-1:0]                      p_be;
  tcdm_ini_t  [`TCDM_NUM_PORTS-1:0]                      p_ini;
  logic       [`TCDM_NUM_PORTS-1:0]                      p_ready;
  logic       [`TCDM_NUM_BANKS-1:0]                      b_valid;
  logic       [`TCDM_NUM_BANKS-1:0]                      b_ready;
  logic       [`TCDM_NUM_BANKS-1:0][`TCDM_NUM_PORTS-1:0] bank_req;
  logic       [`TCDM_NUM_BANKS-1:0][`TCDM_NUM_PORTS-1:0] gnt;
  logic       [`TCDM_NUM_PORTS-1:0][`TCDM_NUM_BANKS-1:0] gnt_t;
  tcdm_ini_t  [`TCDM_NUM_BANKS-1:0]                      win;
  tcdm_ini_t  [`TCDM_NUM_BANKS-1:0]                      rr_q;
  logic       [`TCDM_NUM_BANKS-1:0]                      hold_q;
  tcdm_ini_t  [`TCDM_NUM_BANKS-1:0]                      hold_idx_q;

  for (genvar p = 0; p < `TCDM_NUM_PORTS; p++) begin : gen_port
    assign p_valid[p]     = req_s[p].valid;
    assign p_addr[p]      = req_s[p].addr;
    assign p_wen[p]       = req_s[p].wen;
    assign p_wdata[p]     = req_s[p].wdata;
    assign p_be[p]        = req_s[p].be;
    assign p_ini[p]       = req_s[p].ini;
    assign req_s[p].ready = p_ready[p];

    a_port_one_bank: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(gnt_t[p]));
  end

  always_comb begin
    logic      found;
    tcdm_ini_t idx;
    for (int b = 0; b < `TCDM_NUM_BANKS; b++) begin
      for (int p = 0; p < `TCDM_NUM_PORTS; p++) begin
        bank_req[b][p] = p_valid[p] && (p_addr[p].fields.bank == tcdm_bank_idx_t'(b));
      end
      // First requester at or after the pointer
      found  = 1'b0;
      win[b] = rr_q[b];
      for (int k = 0; k < `TCDM_NUM_PORTS; k++) begin
        idx = rr_q[b] + tcdm_ini_t'(k);
        if (!found && bank_req[b][idx]) begin
          found  = 1'b1;
          win[b] = idx;
        end
      end
      // Keep the stalled winner so the bank request stays stable
      if (hold_q[b]) begin
        win[b] = hold_idx_q[b];
      end
      b_valid[b]      = |bank_req[b];
      gnt[b]          = '0;
      gnt[b][win[b]]  = b_valid[b];
    end
    for (int p = 0; p < `TCDM_NUM_PORTS; p++) begin
      for (int b = 0; b < `TCDM_NUM_BANKS; b++) begin
        gnt_t[p][b] = gnt[b][p];
      end
      p_ready[p] = |(gnt_t[p] & b_ready);
    end
  end

  for (genvar b = 0; b < `TCDM_NUM_BANKS; b++) begin : gen_bank
    assign bank_m[b].valid = b_valid[b];
    assign bank_m[b].addr  = p_addr[win[b]];
    assign bank_m[b].wen   = p_wen[win[b]];
    assign bank_m[b].wdata = p_wdata[win[b]];
    assign bank_m[b].be    = p_be[win[b]];
    assign bank_m[b].ini   = p_ini[win[b]];
    assign b_ready[b]      = bank_m[b].ready;

    a_bank_one_port: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(gnt[b]));
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q       <= '0;
      hold_q     <= '0;
      hold_idx_q <= '0;
    end else begin
      for (int b = 0; b < `TCDM_NUM_BANKS; b++) begin
        hold_q[b]     <= b_valid[b] & ~b_ready[b];
        hold_idx_q[b] <= win[b];
        if (b_valid[b] && b_ready[b]) begin
          rr_q[b] <= win[b] + tcdm_ini_t'(1);
        end
      end
    end
  end

endmodule

/* hw/tcdm_bank.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TCDM bank: byte-enabled word memory with a registered response
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "tcdm_config.svh"

module tcdm_bank (
  input  logic        clk_i,
  input  logic        rst_n_i,
  tcdm_req_if.slave   req_s,
  tcdm_resp_if.master resp_m
);
  import tcdm_pkg::*;

  tcdm_data_t mem_q [`TCDM_BANK_ROWS];
  logic       rsp_valid_q;
  tcdm_data_t rsp_rdata_q;
  tcdm_ini_t  rsp_ini_q;
  logic       req_hs;
  tcdm_row_t  row;

  assign row = req_s.addr.fields.row;

  // Take a new request while the response slot empties
  assign req_s.ready = ~rsp_valid_q | resp_m.ready;
  assign req_hs      = req_s.valid & req_s.ready;

  assign resp_m.valid = rsp_valid_q;
  assign resp_m.rdata = rsp_rdata_q;
  assign resp_m.ini   = rsp_ini_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (req_hs) begin
      rsp_valid_q <= 1'b1;
    end else if (resp_m.ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      rsp_ini_q <= req_s.ini;
      if (req_s.wen) begin
        for (int i = 0; i < `TCDM_DATA_WIDTH / 8; i++) begin
          if (req_s.be[i]) begin
            mem_q[row][i*8 +: 8] <= req_s.wdata[i*8 +: 8];
          end
        end
        // Writes answer with zero
        rsp_rdata_q <= '0;
      end else begin
        rsp_rdata_q <= mem_q[row];
      end
    end
  end

  a_rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_m.valid && !resp_m.ready |=>
      resp_m.valid && $stable(resp_m.rdata) && $stable(resp_m.ini));

endmodule

/* hw/tcdm_resp_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Response stage: steers bank responses to their initiator's output register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "tcdm_config.svh"

module tcdm_resp_stage (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  tcdm_resp_if.slave                                 bank_s [`TCDM_NUM_BANKS],
  output logic                 [`TCDM_NUM_PORTS-1:0] resp_valid_o,
  output tcdm_pkg::tcdm_data_t [`TCDM_NUM_PORTS-1:0] resp_rdata_o,
  input  logic                 [`TCDM_NUM_PORTS-1:0] resp_ready_i
);
  import tcdm_pkg::*;

  logic       [`TCDM_NUM_BANKS-1:0]                      b_valid;
  tcdm_data_t [`TCDM_NUM_BANKS-1:0]                      b_rdata;
  tcdm_ini_t  [`TCDM_NUM_BANKS-1:0]                      b_ini;
  logic       [`TCDM_NUM_BANKS-1:0]                      b_ready;
  logic       [`TCDM_NUM_PORTS-1:0]                      port_free;
  logic       [`TCDM_NUM_PORTS-1:0][`TCDM_NUM_BANKS-1:0] sel;
  logic       [`TCDM_NUM_PORTS-1:0]                      load;
  tcdm_data_t [`TCDM_NUM_PORTS-1:0]                      load_data;

  // Output register empty or being drained this cycle
  assign port_free = ~resp_valid_o | resp_ready_i;

  for (genvar b = 0; b < `TCDM_NUM_BANKS; b++) begin : gen_bank
    assign b_valid[b]      = bank_s[b].valid;
    assign b_rdata[b]      = bank_s[b].rdata;
    assign b_ini[b]        = bank_s[b].ini;
    assign bank_s[b].ready = b_ready[b];
  end

  always_comb begin
    for (int p = 0; p < `TCDM_NUM_PORTS; p++) begin
      load_data[p] = '0;
      for (int b = 0; b < `TCDM_NUM_BANKS; b++) begin
        sel[p][b] = b_valid[b] && (b_ini[b] == tcdm_ini_t'(p));
        if (sel[p][b]) begin
          load_data[p] = b_rdata[b];
        end
      end
      load[p] = (|sel[p]) && port_free[p];
    end
    for (int b = 0; b < `TCDM_NUM_BANKS; b++) begin
      b_ready[b] = port_free[b_ini[b]];
    end
  end

  for (genvar p = 0; p < `TCDM_NUM_PORTS; p++) begin : gen_port
    // One outstanding request per port keeps bank responses apart
    a_one_source: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(sel[p]));
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_valid_o <= '0;
    end else begin
      for (int p = 0; p < `TCDM_NUM_PORTS; p++) begin
        if (load[p]) begin
          resp_valid_o[p] <= 1'b1;
        end else if (resp_ready_i[p]) begin
          resp_valid_o[p] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int p = 0; p < `TCDM_NUM_PORTS; p++) begin
      if (load[p]) begin
        resp_rdata_o[p] <= load_data[p];
      end
    end
  end

endmodule

/* hw/mempool_local_tcdm.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Local TCDM path of a group: four tile ports onto four interleaved banks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "tcdm_config.svh"

module mempool_local_tcdm (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  // Tile requests
  input  logic                 [`TCDM_NUM_PORTS-1:0] req_valid_i,
  output logic                 [`TCDM_NUM_PORTS-1:0] req_ready_o,
  input  tcdm_pkg::tcdm_addr_t [`TCDM_NUM_PORTS-1:0] req_addr_i,
  input  logic                 [`TCDM_NUM_PORTS-1:0] req_wen_i,
  input  tcdm_pkg::tcdm_data_t [`TCDM_NUM_PORTS-1:0] req_wdata_i,
  input  tcdm_pkg::tcdm_strb_t [`TCDM_NUM_PORTS-1:0] req_be_i,
  // Tile responses
  output logic                 [`TCDM_NUM_PORTS-1:0] resp_valid_o,
  input  logic                 [`TCDM_NUM_PORTS-1:0] resp_ready_i,
  output tcdm_pkg::tcdm_data_t [`TCDM_NUM_PORTS-1:0] resp_rdata_o
);
  import tcdm_pkg::*;

  tcdm_req_if  dec_if       [`TCDM_NUM_PORTS] ();
  tcdm_req_if  bank_req_if  [`TCDM_NUM_BANKS] ();
  tcdm_resp_if bank_resp_if [`TCDM_NUM_BANKS] ();
  tcdm_resp_if port_resp_if [`TCDM_NUM_PORTS] ();

  // Top-level response handshake, watched by the request stage
  for (genvar p = 0; p < `TCDM_NUM_PORTS; p++) begin : gen_port_resp
    assign port_resp_if[p].valid = resp_valid_o[p];
    assign port_resp_if[p].ready = resp_ready_i[p];
    assign port_resp_if[p].rdata = resp_rdata_o[p];
    assign port_resp_if[p].ini   = tcdm_ini_t'(p);
  end

  tcdm_req_stage i_req_stage (
    .clk_i       (clk_i       ),
    .rst_n_i     (rst_n_i     ),
    .req_valid_i (req_valid_i ),
    .req_ready_o (req_ready_o ),
    .req_addr_i  (req_addr_i  ),
    .req_wen_i   (req_wen_i   ),
    .req_wdata_i (req_wdata_i ),
    .req_be_i    (req_be_i    ),
    .dec_o       (dec_if      ),
    .resp_mon    (port_resp_if)
  );

  tcdm_bank_arbiter i_bank_arbiter (
    .clk_i   (clk_i      ),
    .rst_n_i (rst_n_i    ),
    .req_s   (dec_if     ),
    .bank_m  (bank_req_if)
  );

  for (genvar b = 0; b < `TCDM_NUM_BANKS; b++) begin : gen_bank
    tcdm_bank i_bank (
      .clk_i   (clk_i          ),
      .rst_n_i (rst_n_i        ),
      .req_s   (bank_req_if[b] ),
      .resp_m  (bank_resp_if[b])
    );
  end

  tcdm_resp_stage i_resp_stage (
    .clk_i        (clk_i       ),
    .rst_n_i      (rst_n_i     ),
    .bank_s       (bank_resp_if),
    .resp_valid_o (resp_valid_o),
    .resp_rdata_o (resp_rdata_o),
    .resp_ready_i (resp_ready_i)
  );

endmodule

/* verification/tcdm_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Local TCDM testbench: directed and random traffic on all four ports,
// checked against a reference memory model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "tcdm_config.svh"

module tcdm_tb;
  import tcdm_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int SEED       = 14;
  localparam int NP         = `TCDM_NUM_PORTS;
  localparam int NB         = `TCDM_NUM_BANKS;
  // Rows of each bank that one port owns
  localparam int SLOTS      = `TCDM_BANK_ROWS / NP;
  localparam int T3_LEN     = 14;
  localparam int T4_ROUNDS  = 8;
  localparam int T5_LEN     = 40;
  localparam int T6_LEN     = 100;
  localparam int QDEPTH     = 512;
  localparam int NUM_TXN    =
    NP * (2 * NB * SLOTS + 2 * T3_LEN + 2 * T4_ROUNDS + T5_LEN + T6_LEN);
  // Budget as if no two transactions overlapped
  localparam int WATCHDOG_LIMIT = (NUM_TXN * 16 + 32) * CLK_PERIOD;

  logic                clk_i = 1'b0;
  logic                rst_n_i;
  logic       [NP-1:0] req_valid_i;
  logic       [NP-1:0] req_ready_o;
  tcdm_addr_t [NP-1:0] req_addr_i;
  logic       [NP-1:0] req_wen_i;
  tcdm_data_t [NP-1:0] req_wdata_i;
  tcdm_strb_t [NP-1:0] req_be_i;
  logic       [NP-1:0] resp_valid_o;
  logic       [NP-1:0] resp_ready_i;
  tcdm_data_t [NP-1:0] resp_rdata_o;
  logic                bp_on;

  tcdm_data_t ref_mem  [NB * `TCDM_BANK_ROWS];
  tcdm_data_t exp_data [NP][QDEPTH];
  int         exp_head [NP] = '{default: 0};
  int         exp_tail [NP] = '{default: 0};
  int         sent_cnt = 0;
  int         resp_cnt = 0;
  int         err_cnt  = 0;
  int         test_cnt = 0;
  int         fail_cnt = 0;

  mempool_local_tcdm dut0 (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Word index is the byte address without its offset bits
  function automatic tcdm_data_t ref_access(input tcdm_addr_t addr, input logic wen,
                                            input tcdm_data_t wdata, input tcdm_strb_t be);
    int word;
    word = int'(addr[`TCDM_ADDR_WIDTH-1:2]);
    if (!wen) begin
      return ref_mem[word];
    end
    for (int i = 0; i < `TCDM_DATA_WIDTH / 8; i++) begin
      if (be[i]) begin
        ref_mem[word][i*8 +: 8] = wdata[i*8 +: 8];
      end
    end
    return '0;
  endfunction

  function automatic tcdm_addr_t make_addr(input int p, input int bank, input int slot);
    tcdm_addr_fields_t f;
    // Row mod port count is the port itself
    f.row    = tcdm_row_t'(slot * NP + p);
    f.bank   = tcdm_bank_idx_t'(bank);
    f.offset = 2'($urandom);
    return tcdm_addr_t'(f);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic issue(input int p, input tcdm_addr_t addr, input logic wen,
                       input tcdm_data_t wdata, input tcdm_strb_t be);
    logic rdy;
    @(posedge clk_i);
    req_valid_i[p] <= 1'b1;
    req_addr_i[p]  <= addr;
    req_wen_i[p]   <= wen;
    req_wdata_i[p] <= wdata;
    req_be_i[p]    <= be;
    // Ready sampled mid-cycle, before the edge that uses it
    do begin
      @(negedge clk_i);
      rdy = req_ready_o[p];
      @(posedge clk_i);
    end while (!rdy);
    // Accepted on this edge
    exp_data[p][exp_tail[p] % QDEPTH] = ref_access(addr, wen, wdata, be);
    exp_tail[p]++;
    sent_cnt++;
    req_valid_i[p] <= 1'b0;
  endtask

  task automatic port_traffic(input int p, input int test);
    logic wen;
    case (test)
      2: begin
        // Every owned word written once, then all read back
        for (int k = 0; k < 2 * NB * SLOTS; k++) begin
          issue(p, make_addr(p, k % NB, (k / NB) % SLOTS), k < NB * SLOTS, $urandom, 4'hf);
        end
      end
      3: begin
        for (int k = 1; k <= T3_LEN; k++) begin
          issue(p, make_addr(p, k % NB, k), 1'b1, $urandom, tcdm_strb_t'(k));
          issue(p, make_addr(p, k % NB, k), 1'b0, '0, 4'hf);
        end
      end
      default: begin
        repeat (test == 5 ? T5_LEN : T6_LEN) begin
          wen = 1'($urandom);
          issue(p, make_addr(p, int'($urandom % NB), int'($urandom % SLOTS)), wen,
                $urandom, tcdm_strb_t'($urandom_range(15, 1)));
        end
      end
    endcase
  endtask

  task automatic drain();
    do begin
      @(negedge clk_i);
    end while (sent_cnt != resp_cnt);
    @(posedge clk_i);
  endtask

  // All ports hit the same bank on the same edge
  task automatic same_bank_round(input int round, input logic wen);
    fork
      issue(0, make_addr(0, round % NB, round), wen, $urandom, 4'hf);
      issue(1, make_addr(1, round % NB, round), wen, $urandom, 4'hf);
      issue(2, make_addr(2, round % NB, round), wen, $urandom, 4'hf);
      issue(3, make_addr(3, round % NB, round), wen, $urandom, 4'hf);
    join
    drain();
  endtask

  task automatic run_test(input string name, input int test);
    int errs;
    errs = err_cnt;
    if (test == 1) begin
      drain();
    end else if (test == 4) begin
      for (int r = 0; r < T4_ROUNDS; r++) begin
        same_bank_round(r, 1'b1);
        same_bank_round(r, 1'b0);
      end
    end else begin
      fork
        port_traffic(0, test);
        port_traffic(1, test);
        port_traffic(2, test);
        port_traffic(3, test);
      join
      drain();
    end
    test_cnt++;
    if (err_cnt == errs) begin
      $display("Test %0d (%s): ok", test_cnt, name);
    end else begin
      fail_cnt++;
      $display("Test %0d (%s): %0d errors", test_cnt, name, err_cnt - errs);
    end
  endtask

  initial begin
    resp_ready_i <= '1;
    forever begin
      @(posedge clk_i);
      if (bp_on) begin
        resp_ready_i <= NP'($urandom);
      end else begin
        resp_ready_i <= '1;
      end
    end
  end

  // Port state and responses, sampled mid-cycle
  always @(negedge clk_i) begin
    logic busy;
    for (int p = 0; p < NP; p++) begin
      busy = exp_head[p] != exp_tail[p];
      check_value($sformatf("req_ready_o[%0d]", p), 32'(req_ready_o[p]), 32'(!busy));
      if (!busy) begin
        check_value($sformatf("resp_valid_o[%0d]", p), 32'(resp_valid_o[p]), 32'h0);
      end else if (resp_valid_o[p] && resp_ready_i[p]) begin
        check_value($sformatf("resp_rdata_o[%0d]", p), resp_rdata_o[p],
                    exp_data[p][exp_head[p] % QDEPTH]);
        exp_head[p]++;
        resp_cnt++;
      end
    end
  end

  initial begin
    #(WATCHDOG_LIMIT);
    $display("Watchdog expired after %0d time units with %0d of %0d responses received",
             WATCHDOG_LIMIT, resp_cnt, sent_cnt);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    int seed_ret;
    seed_ret = $urandom(SEED);
    rst_n_i     <= 1'b0;
    req_valid_i <= '0;
    req_addr_i  <= '0;
    req_wen_i   <= '0;
    req_wdata_i <= '0;
    req_be_i    <= '0;
    bp_on       <= 1'b0;
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    run_test("reset state", 1);
    run_test("full write and read back of every word", 2);
    run_test("byte-enabled partial writes", 3);
    run_test("all ports on one bank", 4);
    bp_on <= 1'b1;
    run_test("random response back-pressure", 5);
    bp_on <= 1'b0;
    run_test("random mixed reads and writes", 6);
    $display("Tests run: %0d, failed: %0d, errors: %0d, responses: %0d",
             test_cnt, fail_cnt, err_cnt, resp_cnt);
    if (err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+include
hw/tcdm_pkg.sv
hw/tcdm_if.sv
hw/tcdm_req_stage.sv
hw/tcdm_bank_arbiter.sv
hw/tcdm_bank.sv
hw/tcdm_resp_stage.sv
hw/mempool_local_tcdm.sv
verification/tcdm_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the local TCDM testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -j 0 --top-module tcdm_tb -f verilog.f -o tcdm_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tcdm_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
  echo "Failure reported in $LOG"
  exit 1
fi

exit 0
